//--- project.f
src/blkmv_pkg.sv
src/blkmv_regs.sv
src/dram_block_reader.sv
src/section_buffer.sv
src/section_drain.sv
src/blkmv_top.sv
sim/dram_model.sv
sim/tb_blkmv.sv

//--- Bender.yml
package:
  name: blkmv

sources:
  - files:
      - src/blkmv_pkg.sv
      - src/blkmv_regs.sv
      - src/dram_block_reader.sv
      - src/section_buffer.sv
      - src/section_drain.sv
      - src/blkmv_top.sv
  - target: simulation
    files:
      - sim/dram_model.sv
      - sim/tb_blkmv.sv

//--- sim/tb_blkmv.sv
// Testbench for the block mover; runs APB setup, block copies and stream checks against a DRAM model
`timescale 1ns/1ns

module tb_blkmv;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_BLOCKS = 6;
  // Blocks plus one spare slot for reset and register tests
  localparam int WATCHDOG_NS = (NUM_BLOCKS + 1) * 400 * CLK_PERIOD;

  logic CLK;
  logic RST;
  logic psel;
  logic penable;
  logic pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic [blkmv_pkg::ADDR_W-1:0] dram_addr;
  logic dram_req;
  logic [blkmv_pkg::DATA_W-1:0] dram_rdata;
  logic [blkmv_pkg::DATA_W-1:0] out_data;
  logic out_valid;
  logic out_last;
  logic out_ready;

  // Scoreboard of expected output words
  logic [blkmv_pkg::DATA_W-1:0] exp_data [0:255];
  logic exp_last [0:255];
  int push_idx = 0;
  int pop_idx = 0;

  // Expected fetch of the current block
  logic [blkmv_pkg::ADDR_W-1:0] fetch_addr_tb = '0;
  int fetch_left_tb = 0;
  logic req_prev = 1'b0;

  logic stall_prev = 1'b0;
  logic [blkmv_pkg::DATA_W-1:0] prev_data = '0;
  logic chk_prdata = 1'b0;
  logic [31:0] exp_prdata = '0;
  logic exp_slverr = 1'b0;
  logic go_seen = 1'b0;
  logic rand_ready = 1'b0;
  logic [15:0] lfsr_state = 16'd71;

  blkmv_top dut0 (.CLK, .RST, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .pslverr, .dram_addr, .dram_req, .dram_rdata, .out_data, .out_valid, .out_last, .out_ready);

  dram_model dram0 (.CLK, .dram_addr, .dram_req, .dram_rdata);

  initial
  begin
    CLK = 1'b0;
    forever
      #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  task automatic fail_stop();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
    fail_stop();
  endtask

  task automatic report_problem(input string why);
    $display("%s at %0t ns", why, $time);
    fail_stop();
  endtask

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic logic [31:0] build_ctrl(input logic [4:0] cnt, input logic [1:0] sect);
    return (32'h1 << blkmv_pkg::CTRL_GO_BIT) | (32'(sect) << blkmv_pkg::CTRL_SECT_LSB) | 32'(cnt);
  endfunction

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic err);
    @(posedge CLK);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    exp_slverr = err;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(posedge CLK);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, input logic check, input logic [31:0] expected,
    input logic err, output logic [31:0] data);
    @(posedge CLK);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    chk_prdata = check;
    exp_prdata = expected;
    exp_slverr = err;
    @(posedge CLK);
    #1;
    penable = 1'b1;
    @(negedge CLK);
    data = prdata;
    @(posedge CLK);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    chk_prdata = 1'b0;
  endtask

  // Loads the expected fetch and stream, then writes the go
  task automatic run_block(input logic [11:0] addr, input logic [4:0] cnt, input logic [1:0] sect);
    int len;
    len = int'(cnt) + 1 + int'(addr[0]);
    if (len % 2 != 0)
      len = len + 1;
    apb_write(blkmv_pkg::REG_START, 32'(addr), 1'b0);
    fetch_addr_tb <= {addr[11:1], 1'b0};
    fetch_left_tb <= len;
    for (int i = 0; i <= int'(cnt); i++)
    begin
      exp_data[push_idx] = dram0.mem[addr + 12'(i)];
      exp_last[push_idx] = (i == int'(cnt));
      push_idx = push_idx + 1;
    end
    go_seen = 1'b1;
    apb_write(blkmv_pkg::REG_CTRL, build_ctrl(cnt, sect), 1'b0);
  endtask

  task automatic wait_drained();
    while (pop_idx != push_idx)
      @(posedge CLK);
  endtask

  // Reference state follows the DUT ports
  always @(posedge CLK)
  begin
    req_prev <= dram_req;
    stall_prev <= out_valid & ~out_ready;
    prev_data <= out_data;
    if (dram_req)
    begin
      fetch_addr_tb <= fetch_addr_tb + 1'b1;
      fetch_left_tb <= fetch_left_tb - 1;
    end
    if (out_valid && out_ready)
      pop_idx <= pop_idx + 1;
  end

  a_pready: assert property (@(posedge CLK) disable iff (!RST) pready)
    else report_mismatch("pready", 1, $sampled(pready));
  a_pslverr: assert property (@(posedge CLK) disable iff (!RST)
    (psel && penable) |-> pslverr == exp_slverr)
    else report_mismatch("pslverr", $sampled(exp_slverr), $sampled(pslverr));
  a_prdata: assert property (@(posedge CLK) disable iff (!RST)
    (psel && penable && !pwrite && chk_prdata) |-> prdata == exp_prdata)
    else report_mismatch("prdata", $sampled(exp_prdata), $sampled(prdata));

  // Quiet outputs between reset and the first go
  a_idle_req: assert property (@(posedge CLK) disable iff (!RST) !go_seen |-> !dram_req)
    else report_mismatch("dram_req", 0, $sampled(dram_req));
  a_idle_valid: assert property (@(posedge CLK) disable iff (!RST) !go_seen |-> !out_valid)
    else report_mismatch("out_valid", 0, $sampled(out_valid));

  a_fetch_addr: assert property (@(posedge CLK) disable iff (!RST)
    dram_req |-> dram_addr == fetch_addr_tb)
    else report_mismatch("dram_addr", $sampled(fetch_addr_tb), $sampled(dram_addr));
  a_fetch_extra: assert property (@(posedge CLK) disable iff (!RST)
    dram_req |-> fetch_left_tb > 0)
    else report_problem("DRAM request issued beyond the expected fetch length");
  a_fetch_short: assert property (@(posedge CLK) disable iff (!RST)
    (req_prev && !dram_req) |-> fetch_left_tb == 0)
    else report_mismatch("fetch words left", 0, $sampled(fetch_left_tb));

  a_word_expected: assert property (@(posedge CLK) disable iff (!RST)
    (out_valid && out_ready) |-> pop_idx < push_idx)
    else report_problem("Output word appeared with none expected");
  a_out_data: assert property (@(posedge CLK) disable iff (!RST)
    (out_valid && out_ready) |-> out_data == exp_data[pop_idx])
    else report_mismatch("out_data", $sampled(exp_data[pop_idx]), $sampled(out_data));
  a_out_last: assert property (@(posedge CLK) disable iff (!RST)
    (out_valid && out_ready) |-> out_last == exp_last[pop_idx])
    else report_mismatch("out_last", $sampled(exp_last[pop_idx]), $sampled(out_last));

  // Stalled word must stay put
  a_hold_valid: assert property (@(posedge CLK) disable iff (!RST) stall_prev |-> out_valid)
    else report_mismatch("out_valid", 1, $sampled(out_valid));
  a_hold_data: assert property (@(posedge CLK) disable iff (!RST)
    stall_prev |-> out_data == prev_data)
    else report_mismatch("out_data", $sampled(prev_data), $sampled(out_data));

  initial
  begin
    logic [15:0] bit_val;
    forever
    begin
      @(posedge CLK);
      #1;
      if (rand_ready)
      begin
        take_bits(1, bit_val);
        out_ready = bit_val[0];
      end
      else
        out_ready = 1'b1;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    report_problem("Timeout: the run did not finish in the allowed time");
  end

  initial
  begin
    logic [15:0] word;
    logic [31:0] rd;
    RST = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    out_ready = 1'b1;
    for (int a = 0; a < (1 << blkmv_pkg::ADDR_W); a++)
    begin
      take_bits(16, word);
      dram0.mem[a] = word;
    end
    repeat (4) @(posedge CLK);
    #1;
    RST = 1'b1;
    repeat (10) @(posedge CLK);

    // Register access
    apb_write(blkmv_pkg::REG_START, 32'h0000_0123, 1'b0);
    apb_read(blkmv_pkg::REG_START, 1'b1, 32'h0000_0123, 1'b0, rd);
    apb_write(blkmv_pkg::REG_START, 32'hFFFF_FABC, 1'b0);
    apb_read(blkmv_pkg::REG_START, 1'b1, 32'h0000_0ABC, 1'b0, rd);
    apb_read(12'h00C, 1'b0, 32'h0, 1'b1, rd);
    apb_write(12'h010, 32'h1, 1'b1);

    // Even start with trailing pad, then odd starts
    run_block(12'h040, 5'd6, 2'd1);
    wait_drained();
    apb_read(blkmv_pkg::REG_STATUS, 1'b1, 32'h0000_0100, 1'b0, rd);
    run_block(12'h101, 5'd4, 2'd2);
    wait_drained();
    run_block(12'h205, 5'd5, 2'd3);
    wait_drained();

    // Random back-pressure
    rand_ready = 1'b1;
    run_block(12'h333, 5'd31, 2'd0);
    wait_drained();
    run_block(12'h7FF, 5'd0, 2'd2);
    wait_drained();
    rand_ready = 1'b0;

    // Go while the reader is busy is dropped
    run_block(12'h400, 5'd31, 2'd1);
    rd = '0;
    while (!rd[0])
      apb_read(blkmv_pkg::REG_STATUS, 1'b0, 32'h0, 1'b0, rd);
    apb_write(blkmv_pkg::REG_CTRL, build_ctrl(5'd3, 2'd2), 1'b0);
    wait_drained();
    apb_read(blkmv_pkg::REG_STATUS, 1'b1, 32'(NUM_BLOCKS) << 8, 1'b0, rd);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- sim/dram_model.sv
// Testbench DRAM read port; returns the word at the requested address after the fixed latency
`timescale 1ns/1ns

module dram_model
(
  input  logic CLK,
  input  logic [blkmv_pkg::ADDR_W-1:0] dram_addr,
  input  logic dram_req,
  output logic [blkmv_pkg::DATA_W-1:0] dram_rdata
);

  // Filled by the testbench before the first request
  logic [blkmv_pkg::DATA_W-1:0] mem [0:(1 << blkmv_pkg::ADDR_W) - 1];
  logic [blkmv_pkg::DATA_W-1:0] lat_pipe [0:blkmv_pkg::DRAM_LAT-1];

  assign dram_rdata = lat_pipe[blkmv_pkg::DRAM_LAT-1];

  always @(posedge CLK)
  begin
    lat_pipe[0] <= dram_req ? mem[dram_addr] : '0;
    for (int i = 1; i < blkmv_pkg::DRAM_LAT; i++)
      lat_pipe[i] <= lat_pipe[i-1];
  end

endmodule

//--- src/blkmv_top.sv
// Block mover top level joining the APB registers, DRAM reader, line buffer and drain
`timescale 1ns/1ns

module blkmv_top
(
  input  logic CLK,
  input  logic RST,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output logic [blkmv_pkg::ADDR_W-1:0] dram_addr,
  output logic dram_req,
  input  logic [blkmv_pkg::DATA_W-1:0] dram_rdata,
  output logic [blkmv_pkg::DATA_W-1:0] out_data,
  output logic out_valid,
  output logic out_last,
  input  logic out_ready
);

  blkmv_pkg::blk_req_t req;
  blkmv_pkg::buf_wr_t wr;
  blkmv_pkg::drain_job_t job;
  logic req_valid;
  logic wr_en;
  logic job_valid;
  logic job_ready;
  logic reader_busy;
  logic drain_busy;
  logic block_done;
  logic [blkmv_pkg::SECT_W-1:0] rd_sect;
  logic [blkmv_pkg::IDX_W-1:0] rd_idx;
  logic rd_en;
  logic [blkmv_pkg::DATA_W-1:0] rd_data;

  blkmv_regs regs0 (.CLK, .RST, .psel, .penable, .pwrite, .paddr, .pwdata,
    .reader_busy, .drain_busy, .block_done, .prdata, .pready, .pslverr, .req, .req_valid);

  dram_block_reader reader0 (.CLK, .RST, .req, .req_valid, .dram_rdata, .job_ready,
    .dram_addr, .dram_req, .wr, .wr_en, .job, .job_valid, .busy(reader_busy), .block_done);

  section_buffer buf0 (.CLK, .wr, .wr_en, .rd_sect, .rd_idx, .rd_en, .rd_data);

  section_drain drain0 (.CLK, .RST, .job, .job_valid, .rd_data, .out_ready, .job_ready,
    .rd_sect, .rd_idx, .rd_en, .out_data, .out_valid, .out_last, .busy(drain_busy));

endmodule

//--- src/section_drain.sv
// Streams a finished section out of the line buffer on a valid/ready port
`timescale 1ns/1ns

module section_drain
(
  input  logic CLK,
  input  logic RST,
  input  blkmv_pkg::drain_job_t job,
  input  logic job_valid,
  input  logic [blkmv_pkg::DATA_W-1:0] rd_data,
  input  logic out_ready,
  output logic job_ready,
  output logic [blkmv_pkg::SECT_W-1:0] rd_sect,
  output logic [blkmv_pkg::IDX_W-1:0] rd_idx,
  output logic rd_en,
  output logic [blkmv_pkg::DATA_W-1:0] out_data,
  output logic out_valid,
  output logic out_last,
  output logic busy
);

  logic [blkmv_pkg::CNT_W-1:0] last_idx;
  logic rd_pend;
  logic take;

  assign job_ready = ~busy;
  assign take = out_valid & out_ready;

  // Next read only when the output slot is empty or being taken
  assign rd_en = rd_pend & (~out_valid | out_ready);

  // The buffer read register is the data half of the output slot
  assign out_data = rd_data;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy <= 1'b0;
      rd_pend <= 1'b0;
      rd_idx <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end
    else
    begin
      if (job_valid & job_ready)
      begin
        busy <= 1'b1;
        rd_pend <= 1'b1;
        rd_idx <= '0;
      end

      if (rd_en)
      begin
        out_valid <= 1'b1;
        out_last <= (rd_idx == last_idx);
        rd_idx <= rd_idx + 1'b1;
        if (rd_idx == last_idx)
          rd_pend <= 1'b0;
      end
      else if (take)
      begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
        // Free once the final word has left
        if (out_last)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (job_valid & job_ready)
    begin
      rd_sect <= job.sect;
      last_idx <= job.cnt;
    end
  end

endmodule

//--- src/section_buffer.sv
// Line buffer of four word sections, one write port and one registered read port
`timescale 1ns/1ns

module section_buffer
(
  input  logic CLK,
  input  blkmv_pkg::buf_wr_t wr,
  input  logic wr_en,
  input  logic [blkmv_pkg::SECT_W-1:0] rd_sect,
  input  logic [blkmv_pkg::IDX_W-1:0] rd_idx,
  input  logic rd_en,
  output logic [blkmv_pkg::DATA_W-1:0] rd_data
);

  // Section number forms the upper address bits
  logic [blkmv_pkg::DATA_W-1:0] mem [0:(1 << blkmv_pkg::SECT_W) * blkmv_pkg::SECT_DEPTH - 1];
  logic [blkmv_pkg::SECT_W+blkmv_pkg::IDX_W-1:0] wr_addr;
  logic [blkmv_pkg::SECT_W+blkmv_pkg::IDX_W-1:0] rd_addr;

  assign wr_addr = {wr.sect, wr.idx};
  assign rd_addr = {rd_sect, rd_idx};

  always_ff @(posedge CLK)
  begin
    if (wr_en)
      mem[wr_addr] <= wr.data;
  end

  // Holds the last word read while rd_en is low
  always_ff @(posedge CLK)
  begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

//--- src/dram_block_reader.sv
// Fetches a block from the DRAM read port in aligned pairs and writes the wanted words to a section
`timescale 1ns/1ns

module dram_block_reader
(
  input  logic CLK,
  input  logic RST,
  input  blkmv_pkg::blk_req_t req,
  input  logic req_valid,
  input  logic [blkmv_pkg::DATA_W-1:0] dram_rdata,
  input  logic job_ready,
  output logic [blkmv_pkg::ADDR_W-1:0] dram_addr,
  output logic dram_req,
  output blkmv_pkg::buf_wr_t wr,
  output logic wr_en,
  output blkmv_pkg::drain_job_t job,
  output logic job_valid,
  output logic busy,
  output logic block_done
);

  logic [blkmv_pkg::FETCH_W-1:0] fetch_sum;
  logic [blkmv_pkg::FETCH_W-1:0] fetch_len;
  logic [blkmv_pkg::FETCH_W-1:0] fetch_left;
  logic [blkmv_pkg::FETCH_W-1:0] words_left;
  logic [blkmv_pkg::IDX_W-1:0] next_idx;
  logic [blkmv_pkg::DRAM_LAT-1:0] vld_pipe;
  logic skip;
  logic start;
  logic ret_vld;
  logic ret_last;

  assign start = req_valid & ~busy;

  // Words wanted plus a leading pad on odd starts, rounded up to a whole pair
  assign fetch_sum = {1'b0, req.cnt} + blkmv_pkg::FETCH_W'(2)
    + {{(blkmv_pkg::FETCH_W-1){1'b0}}, req.addr[0]};
  assign fetch_len = {fetch_sum[blkmv_pkg::FETCH_W-1:1], 1'b0};

  // Top of the pipe marks the cycle that carries read data
  assign ret_vld = vld_pipe[blkmv_pkg::DRAM_LAT-1];
  assign ret_last = ret_vld & ~(|vld_pipe[blkmv_pkg::DRAM_LAT-2:0]);

  assign block_done = job_valid & job_ready;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy <= 1'b0;
      dram_req <= 1'b0;
      dram_addr <= '0;
      fetch_left <= '0;
      vld_pipe <= '0;
      skip <= 1'b0;
      words_left <= '0;
      next_idx <= '0;
      wr_en <= 1'b0;
      job_valid <= 1'b0;
    end
    else
    begin
      vld_pipe <= {vld_pipe[blkmv_pkg::DRAM_LAT-2:0], dram_req};
      wr_en <= 1'b0;

      if (start)
      begin
        busy <= 1'b1;
        dram_req <= 1'b1;
        dram_addr <= {req.addr[blkmv_pkg::ADDR_W-1:1], 1'b0};
        fetch_left <= fetch_len;
        skip <= req.addr[0];
        words_left <= {1'b0, req.cnt} + 1'b1;
        next_idx <= '0;
      end
      else if (dram_req)
      begin
        if (fetch_left == blkmv_pkg::FETCH_W'(1))
          dram_req <= 1'b0;
        else
        begin
          dram_addr <= dram_addr + 1'b1;
          fetch_left <= fetch_left - 1'b1;
        end
      end

      // Leading pad dropped by skip, trailing pad by the word count
      if (ret_vld)
      begin
        if (skip)
          skip <= 1'b0;
        else if (words_left != '0)
        begin
          wr_en <= 1'b1;
          words_left <= words_left - 1'b1;
          next_idx <= next_idx + 1'b1;
        end
      end

      if (ret_last)
        job_valid <= 1'b1;
      else if (block_done)
      begin
        job_valid <= 1'b0;
        busy <= 1'b0;
      end
    end
  end

  // Payload side
  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      job.sect <= req.sect;
      job.cnt <= req.cnt;
    end
    if (ret_vld)
    begin
      wr.sect <= job.sect;
      wr.idx <= next_idx;
      wr.data <= dram_rdata;
    end
  end

endmodule

//--- src/blkmv_regs.sv
// APB register block of the block mover; holds the start address and launches block requests
`timescale 1ns/1ns

module blkmv_regs
(
  input  logic CLK,
  input  logic RST,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  input  logic reader_busy,
  input  logic drain_busy,
  input  logic block_done,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output blkmv_pkg::blk_req_t req,
  output logic req_valid
);

  logic [blkmv_pkg::ADDR_W-1:0] start_addr;
  logic [blkmv_pkg::DONE_W-1:0] done_cnt;
  logic access;
  logic hit_start;
  logic hit_ctrl;
  logic hit_status;
  logic go;
  logic launch;

  assign access = psel & penable;
  assign hit_start = (paddr == blkmv_pkg::REG_START);
  assign hit_ctrl = (paddr == blkmv_pkg::REG_CTRL);
  assign hit_status = (paddr == blkmv_pkg::REG_STATUS);

  // Zero wait states
  assign pready = 1'b1;
  assign pslverr = access & ~(hit_start | hit_ctrl | hit_status);

  assign go = access & pwrite & hit_ctrl & pwdata[blkmv_pkg::CTRL_GO_BIT];
  // Go while the reader is still working is dropped
  assign launch = go & ~reader_busy & ~req_valid;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      start_addr <= '0;
      req_valid <= 1'b0;
      done_cnt <= '0;
    end
    else
    begin
      req_valid <= launch;
      if (access & pwrite & hit_start)
        start_addr <= pwdata[blkmv_pkg::ADDR_W-1:0];
      if (block_done)
        done_cnt <= done_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (launch)
    begin
      req.addr <= start_addr;
      req.cnt <= pwdata[blkmv_pkg::CTRL_CNT_LSB +: blkmv_pkg::CNT_W];
      req.sect <= pwdata[blkmv_pkg::CTRL_SECT_LSB +: blkmv_pkg::SECT_W];
    end
  end

  // Read mux with CTRL reading as zero
  always_comb
  begin
    prdata = '0;
    if (hit_start)
      prdata[blkmv_pkg::ADDR_W-1:0] = start_addr;
    else if (hit_status)
    begin
      prdata[0] = reader_busy;
      prdata[1] = drain_busy;
      prdata[8 +: blkmv_pkg::DONE_W] = done_cnt;
    end
  end

endmodule

//--- src/blkmv_pkg.sv
// Shared widths, APB register map and packed structs for the block mover; referenced by scope
package blkmv_pkg;

  // Data path widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 16;
  localparam int CNT_W = 5;
  localparam int SECT_W = 2;
  localparam int SECT_DEPTH = 32;
  localparam int IDX_W = 5;

  // Fetch length and word count both reach 34 and 32, one bit wider than CNT_W
  localparam int FETCH_W = CNT_W + 1;

  // Read data follows the request address by this many cycles
  localparam int DRAM_LAT = 2;

  // APB byte offsets
  localparam logic [11:0] REG_START = 12'h000;
  localparam logic [11:0] REG_CTRL = 12'h004;
  localparam logic [11:0] REG_STATUS = 12'h008;

  // REG_CTRL field positions
  localparam int CTRL_GO_BIT = 31;
  localparam int CTRL_CNT_LSB = 0;
  localparam int CTRL_SECT_LSB = 8;

  // Width of the completed block counter in REG_STATUS
  localparam int DONE_W = 8;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0] cnt;
    logic [SECT_W-1:0] sect;
  } blk_req_t;

  typedef struct packed {
    logic [SECT_W-1:0] sect;
    logic [IDX_W-1:0] idx;
    logic [DATA_W-1:0] data;
  } buf_wr_t;

  // cnt is the number of words minus one, same encoding as the request
  typedef struct packed {
    logic [SECT_W-1:0] sect;
    logic [CNT_W-1:0] cnt;
  } drain_job_t;

endpackage
